//--- Bender.yml
package:
  name: icache

sources:
  - logic/icache_pkg.sv
  - logic/icache_refill_if.sv
  - logic/icache_rams.sv
  - logic/icache_ctrl.sv
  - logic/icache_biu.sv
  - logic/icache_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/icache_tb.sv

//--- logic/icache_biu.sv
`timescale 1ns/1ns

module icache_biu (
   input  logic              clk,
   input  logic              rst,
   // from the controller
   icache_refill_if.biu      refill,
   // axi ar
   output icache_pkg::addr_t araddr,
   output logic [7:0]        arlen,
   output logic [2:0]        arsize,
   output logic [1:0]        arburst,
   output logic              arvalid,
   input  logic              arready,
   // axi r
   input  icache_pkg::data_t rdata,
   input  logic [1:0]        rresp,
   input  logic              rlast,
   input  logic              rvalid,
   output logic              rready
);
   import icache_pkg::*;

   biu_state_e state;
   // line base, held until ar handshake
   addr_t      line_addr;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= biu_idle;
      end else begin
         case (state)
            biu_idle: begin
               if (refill.req) begin
                  state <= biu_addr;
               end
            end
            biu_addr: begin
               if (arready) begin
                  state <= biu_data;
               end
            end
            biu_data: begin
               // burst done on the rlast beat
               if (rvalid && rlast) begin
                  state <= biu_idle;
               end
            end
            default: begin
               state <= biu_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == biu_idle) && refill.req) begin
         line_addr <= refill.addr;
      end
   end

   // ar fields fixed, always a 4 x 8 byte incr burst
   assign arvalid = (state == biu_addr);
   assign araddr  = line_addr;
   assign arlen   = axi_len_line;
   assign arsize  = axi_size_dword;
   assign arburst = axi_burst_incr;

   // ack on ar accept
   assign refill.ack = arvalid && arready;

   // r beats passed straight through
   assign rready            = (state == biu_data);
   assign refill.data_valid = rready && rvalid;
   assign refill.data_last  = refill.data_valid && rlast;
   assign refill.data       = rdata;
   assign refill.fault      = refill.data_valid && (rresp != axi_resp_okay);

endmodule

//--- logic/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl (
   input  logic                                              clk,
   input  logic                                              rst,
   // fetch port
   input  logic                                              fetch_req,
   input  icache_pkg::addr_t                                 fetch_addr,
   output logic                                              fetch_ack,
   output logic                                              fetch_data_valid,
   output icache_pkg::data_t                                 fetch_data,
   output logic                                              fetch_fault,
   // array read side
   output logic                                              rd_en,
   output icache_pkg::index_t                                rd_index,
   output icache_pkg::beat_t                                 rd_beat,
   input  icache_pkg::tag_entry_t [icache_pkg::num_ways-1:0] rd_tags,
   input  icache_pkg::data_t [icache_pkg::num_ways-1:0]      rd_data,
   input  logic                                              rd_lru,
   // array write side
   output logic                                              wr_en,
   output logic                                              wr_way,
   output icache_pkg::index_t                                wr_index,
   output icache_pkg::beat_t                                 wr_beat,
   output icache_pkg::tag_entry_t                            wr_tag,
   output icache_pkg::data_t                                 wr_data,
   output logic                                              lru_wr,
   output logic                                              lru_way,
   // to the bus unit
   icache_refill_if.ctrl                                     refill
);
   import icache_pkg::*;

   ctrl_state_e state;

   // ic2 stage
   logic   ic2_valid;
   addr_t  ic2_addr;
   tag_t   ic2_tag;
   index_t ic2_index;
   beat_t  ic2_beat;

   // lookup result
   logic [num_ways-1:0] hit_vec;
   logic                hit;
   logic                miss;
   logic                hit_way;
   logic                victim;

   // refill bookkeeping
   logic  miss_way;
   beat_t beat_cnt;
   logic  fault_acc;
   data_t resp_data;
   logic  fill_ok;

   assign ic2_tag   = ic2_addr[tag_lsb +: tag_w];
   assign ic2_index = ic2_addr[index_lsb +: index_w];
   assign ic2_beat  = ic2_addr[dword_lsb +: beat_w];

   // tag compare on the registered ram outputs
   always_comb begin
      for (int w = 0; w < num_ways; w++) begin
         hit_vec[w] = rd_tags[w].valid && (rd_tags[w].tag == ic2_tag);
      end
   end

   assign hit     = ic2_valid && (hit_vec != '0);
   assign miss    = ic2_valid && (hit_vec == '0);
   assign hit_way = hit_vec[1];

   // empty way first, otherwise the lru way
   always_comb begin
      if (!rd_tags[0].valid) begin
         victim = 1'b0;
      end else if (!rd_tags[1].valid) begin
         victim = 1'b1;
      end else begin
         victim = rd_lru;
      end
   end

   // ic1: accept and start the read
   assign fetch_ack = (state == ctrl_idle) && !miss;
   assign rd_en     = fetch_req && fetch_ack;
   assign rd_index  = fetch_addr[index_lsb +: index_w];
   assign rd_beat   = fetch_addr[dword_lsb +: beat_w];

   // ic2 hit, or the word saved during refill
   assign fetch_data_valid = hit || (state == ctrl_respond);
   assign fetch_data       = (state == ctrl_respond) ? resp_data : rd_data[hit_way];
   assign fetch_fault      = (state == ctrl_respond) && fault_acc;

   // whole line from its base
   assign refill.req  = (state == ctrl_miss_req);
   assign refill.addr = {ic2_addr[addr_w-1:offset_w], {offset_w{1'b0}}};

   // each beat goes to the victim way, tag stays invalid until a clean last beat
   assign wr_en    = (state == ctrl_refill) && refill.data_valid;
   assign wr_way   = miss_way;
   assign wr_index = ic2_index;
   assign wr_beat  = beat_cnt;
   assign wr_data  = refill.data;
   assign wr_tag   = '{valid: refill.data_last && !(fault_acc || refill.fault), tag: ic2_tag};
   assign fill_ok  = wr_en && wr_tag.valid;

   // other way becomes lru after a hit or a fill
   assign lru_wr  = hit || fill_ok;
   assign lru_way = hit ? !hit_way : !miss_way;

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= ctrl_idle;
         ic2_valid <= 1'b0;
         beat_cnt  <= '0;
         fault_acc <= 1'b0;
      end else begin
         ic2_valid <= rd_en;
         case (state)
            ctrl_idle: begin
               if (miss) begin
                  state     <= ctrl_miss_req;
                  beat_cnt  <= '0;
                  fault_acc <= 1'b0;
               end
            end
            ctrl_miss_req: begin
               if (refill.ack) begin
                  state <= ctrl_refill;
               end
            end
            ctrl_refill: begin
               if (refill.data_valid) begin
                  beat_cnt  <= beat_cnt + beat_t'(1);
                  fault_acc <= fault_acc || refill.fault;
                  if (refill.data_last) begin
                     state <= ctrl_respond;
                  end
               end
            end
            ctrl_respond: begin
               state <= ctrl_idle;
            end
            default: begin
               state <= ctrl_idle;
            end
         endcase
      end
   end

   // address held through the miss, no acks meanwhile
   always_ff @(posedge clk) begin
      if (rd_en) begin
         ic2_addr <= fetch_addr;
      end
      if ((state == ctrl_idle) && miss) begin
         miss_way <= victim;
      end
      // keep the requested doubleword as it passes
      if (wr_en && (beat_cnt == ic2_beat)) begin
         resp_data <= refill.data;
      end
   end

endmodule

//--- logic/icache_pkg.sv
package icache_pkg;

   // bus and fetch widths
   localparam int addr_w = 32;
   localparam int data_w = 64;

   // line geometry, 4 doublewords = 32 bytes
   localparam int line_beats = 4;
   localparam int beat_w     = $clog2(line_beats);
   localparam int dword_lsb  = 3;
   localparam int offset_w   = dword_lsb + beat_w;

   // 64 sets, two ways
   localparam int index_w  = 6;
   localparam int num_sets = 1 << index_w;
   localparam int num_ways = 2;

   // tag is addr[31:11]
   localparam int index_lsb = offset_w;
   localparam int tag_lsb   = offset_w + index_w;
   localparam int tag_w     = addr_w - tag_lsb;

   // ar field values for a line burst
   localparam logic [7:0] axi_len_line   = 8'd3;
   localparam logic [2:0] axi_size_dword = 3'd3;
   localparam logic [1:0] axi_burst_incr = 2'd1;

   // anything but okay is a fault
   localparam logic [1:0] axi_resp_okay = 2'b00;

   typedef logic [addr_w-1:0]  addr_t;
   typedef logic [data_w-1:0]  data_t;
   typedef logic [tag_w-1:0]   tag_t;
   typedef logic [index_w-1:0] index_t;
   typedef logic [beat_w-1:0]  beat_t;

   // V bit on top, then addr[31:11]
   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

   // lookup and refill sequencing
   typedef enum logic [1:0] {
      ctrl_idle,
      ctrl_miss_req,
      ctrl_refill,
      ctrl_respond
   } ctrl_state_e;

   // ar then r
   typedef enum logic [1:0] {
      biu_idle,
      biu_addr,
      biu_data
   } biu_state_e;

endpackage

//--- logic/icache_rams.sv
`timescale 1ns/1ns

module icache_rams (
   input  logic                                              clk,
   input  logic                                              rst,
   // read port, one cycle latency
   input  logic                                              rd_en,
   input  icache_pkg::index_t                                rd_index,
   input  icache_pkg::beat_t                                 rd_beat,
   output icache_pkg::tag_entry_t [icache_pkg::num_ways-1:0] rd_tags,
   output icache_pkg::data_t [icache_pkg::num_ways-1:0]      rd_data,
   output logic                                              rd_lru,
   // write port, one beat per cycle
   input  logic                                              wr_en,
   input  logic                                              wr_way,
   input  icache_pkg::index_t                                wr_index,
   input  icache_pkg::beat_t                                 wr_beat,
   input  icache_pkg::tag_entry_t                            wr_tag,
   input  icache_pkg::data_t                                 wr_data,
   // lru shares wr_index
   input  logic                                              lru_wr,
   input  logic                                              lru_way
);
   import icache_pkg::*;

   // tag and data storage per way
   tag_t  tag_mem [num_ways][num_sets];
   data_t data_mem [num_ways][num_sets*line_beats];

   // valid bits kept apart so reset can clear them
   logic [num_sets-1:0] valid [num_ways];
   // 1 bit per set, names the way to evict next
   logic [num_sets-1:0] lru;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int w = 0; w < num_ways; w++) begin
            valid[w] <= '0;
         end
         lru <= '0;
      end else begin
         if (wr_en) begin
            valid[wr_way][wr_index] <= wr_tag.valid;
         end
         if (lru_wr) begin
            lru[wr_index] <= lru_way;
         end
      end
   end

   // tag rewritten on every refill beat
   always_ff @(posedge clk) begin
      if (wr_en) begin
         tag_mem[wr_way][wr_index]            <= wr_tag.tag;
         data_mem[wr_way][{wr_index, wr_beat}] <= wr_data;
      end
   end

   // registered read, outputs hold between reads
   always_ff @(posedge clk) begin
      if (rd_en) begin
         for (int w = 0; w < num_ways; w++) begin
            rd_tags[w] <= '{valid: valid[w][rd_index], tag: tag_mem[w][rd_index]};
            rd_data[w] <= data_mem[w][{rd_index, rd_beat}];
         end
         // forward an lru update from ic2 to the same set
         rd_lru <= (lru_wr && (wr_index == rd_index)) ? lru_way : lru[rd_index];
      end
   end

endmodule

//--- logic/icache_refill_if.sv
`timescale 1ns/1ns

interface icache_refill_if;
   import icache_pkg::*;

   // line request, level until ack
   logic  req;
   addr_t addr;
   logic  ack;

   // returned beats
   logic  data_valid;
   logic  data_last;
   data_t data;
   // rresp not okay on this beat
   logic  fault;

   modport ctrl (
      output req,
      output addr,
      input  ack,
      input  data_valid,
      input  data_last,
      input  data,
      input  fault
   );

   modport biu (
      input  req,
      input  addr,
      output ack,
      output data_valid,
      output data_last,
      output data,
      output fault
   );

endinterface

//--- logic/icache_top.sv
`timescale 1ns/1ns

module icache_top (
   input  logic              clk,
   input  logic              rst,
   // fetch port
   input  logic              fetch_req,
   input  icache_pkg::addr_t fetch_addr,
   output logic              fetch_ack,
   output logic              fetch_data_valid,
   output icache_pkg::data_t fetch_data,
   output logic              fetch_fault,
   // axi ar
   output icache_pkg::addr_t araddr,
   output logic [7:0]        arlen,
   output logic [2:0]        arsize,
   output logic [1:0]        arburst,
   output logic              arvalid,
   input  logic              arready,
   // axi r
   input  icache_pkg::data_t rdata,
   input  logic [1:0]        rresp,
   input  logic              rlast,
   input  logic              rvalid,
   output logic              rready
);
   import icache_pkg::*;

   // controller to arrays
   logic                        rd_en;
   index_t                      rd_index;
   beat_t                       rd_beat;
   tag_entry_t [num_ways-1:0]   rd_tags;
   data_t [num_ways-1:0]        rd_data;
   logic                        rd_lru;
   logic                        wr_en;
   logic                        wr_way;
   index_t                      wr_index;
   beat_t                       wr_beat;
   tag_entry_t                  wr_tag;
   data_t                       wr_data;
   logic                        lru_wr;
   logic                        lru_way;

   // controller to bus unit
   icache_refill_if refill ();

   icache_ctrl u_ctrl (
      .clk              (clk             ),
      .rst              (rst             ),
      .fetch_req        (fetch_req       ),
      .fetch_addr       (fetch_addr      ),
      .fetch_ack        (fetch_ack       ),
      .fetch_data_valid (fetch_data_valid),
      .fetch_data       (fetch_data      ),
      .fetch_fault      (fetch_fault     ),
      .rd_en            (rd_en           ),
      .rd_index         (rd_index        ),
      .rd_beat          (rd_beat         ),
      .rd_tags          (rd_tags         ),
      .rd_data          (rd_data         ),
      .rd_lru           (rd_lru          ),
      .wr_en            (wr_en           ),
      .wr_way           (wr_way          ),
      .wr_index         (wr_index        ),
      .wr_beat          (wr_beat         ),
      .wr_tag           (wr_tag          ),
      .wr_data          (wr_data         ),
      .lru_wr           (lru_wr          ),
      .lru_way          (lru_way         ),
      .refill           (refill.ctrl     )
   );

   icache_rams u_rams (
      .clk      (clk     ),
      .rst      (rst     ),
      .rd_en    (rd_en   ),
      .rd_index (rd_index),
      .rd_beat  (rd_beat ),
      .rd_tags  (rd_tags ),
      .rd_data  (rd_data ),
      .rd_lru   (rd_lru  ),
      .wr_en    (wr_en   ),
      .wr_way   (wr_way  ),
      .wr_index (wr_index),
      .wr_beat  (wr_beat ),
      .wr_tag   (wr_tag  ),
      .wr_data  (wr_data ),
      .lru_wr   (lru_wr  ),
      .lru_way  (lru_way )
   );

   icache_biu u_biu (
      .clk     (clk       ),
      .rst     (rst       ),
      .refill  (refill.biu),
      .araddr  (araddr    ),
      .arlen   (arlen     ),
      .arsize  (arsize    ),
      .arburst (arburst   ),
      .arvalid (arvalid   ),
      .arready (arready   ),
      .rdata   (rdata     ),
      .rresp   (rresp     ),
      .rlast   (rlast     ),
      .rvalid  (rvalid    ),
      .rready  (rready    )
   );

endmodule

//--- project.f
+incdir+tests
logic/icache_pkg.sv
logic/icache_refill_if.sv
logic/icache_rams.sv
logic/icache_ctrl.sv
logic/icache_biu.sv
logic/icache_top.sv
tests/icache_tb.sv

//--- tests/icache_tests.svh
`ifndef ICACHE_TESTS_SVH
`define ICACHE_TESTS_SVH

// every task starts and ends 1 ns after a rising edge

task automatic report_test(input string name, input int err_start);
   tests_run++;
   if (errors == err_start) begin
      $display("ok   %s", name);
   end else begin
      tests_failed++;
      $display("bad  %s: %0d errors", name, errors - err_start);
   end
endtask

// one request that waits for ack and then for the data
// lat counts cycles from acceptance
task automatic fetch(input addr_t a, output data_t d, output logic f, output int lat);
   int t;
   d          = '0;
   f          = 1'b0;
   lat        = 0;
   t          = 0;
   fetch_req  = 1'b1;
   fetch_addr = a;
   #2;
   while (!fetch_ack && t < max_wait) begin
      @(posedge clk);
      #3;
      t++;
   end
   if (!fetch_ack) begin
      $display("timeout at %0t ns, fetch_ack never rose for %h", $time, a);
      errors++;
      @(posedge clk);
      #1;
      fetch_req = 1'b0;
      return;
   end
   @(posedge clk);
   #1;
   fetch_req = 1'b0;
   lat       = 1;
   #2;
   while (!fetch_data_valid && lat < max_wait) begin
      // no new accept while a miss is served
      check_bit("fetch_ack", fetch_ack, 1'b0);
      @(posedge clk);
      #3;
      lat++;
   end
   if (!fetch_data_valid) begin
      $display("timeout at %0t ns, no fetch_data_valid for %h", $time, a);
      errors++;
   end
   d = fetch_data;
   f = fetch_fault;
   @(posedge clk);
   #1;
endtask

// clean fetch where a hit needs no AR and one cycle
// a miss needs one AR at the line base
task automatic fetch_check(input addr_t a, input logic exp_hit);
   data_t d;
   logic  f;
   int    lat;
   int    ar_before;
   ar_before = ar_count;
   fetch(a, d, f, lat);
   check_data("fetch_data", d, mem_word(dword_base(a)));
   check_bit("fetch_fault", f, 1'b0);
   if (exp_hit) begin
      check_count("AR count on hit", ar_count - ar_before, 0);
      check_count("hit latency", lat, 1);
   end else begin
      check_count("AR count on miss", ar_count - ar_before, 1);
      check_addr("araddr", last_araddr, line_base(a));
   end
endtask

task automatic test_reset();
   int err_start;
   err_start = errors;
   check_bit("arvalid", arvalid, 1'b0);
   check_bit("rready", rready, 1'b0);
   check_bit("fetch_data_valid", fetch_data_valid, 1'b0);
   report_test("reset", err_start);
endtask

task automatic test_cold_miss();
   int err_start;
   err_start = errors;
   fetch_check(32'h0000_0448, 1'b0);
   check_field("arlen", last_arlen, 8'd3);
   check_field("arsize", {5'b0, last_arsize}, 8'd3);
   check_field("arburst", {6'b0, last_arburst}, 8'd1);
   report_test("cold miss", err_start);
endtask

// rest of the 0x440 line
task automatic test_hits();
   int err_start;
   err_start = errors;
   fetch_check(32'h0000_0440, 1'b1);
   fetch_check(32'h0000_0450, 1'b1);
   fetch_check(32'h0000_045c, 1'b1);
   report_test("hits", err_start);
endtask

// req held high with a new address each accepted cycle
task automatic test_back_to_back();
   addr_t addrs [4];
   data_t exp_q [$];
   int    resp_cyc [$];
   int    err_start;
   int    ar_before;
   int    sent;
   int    got;
   int    cyc;
   err_start  = errors;
   ar_before  = ar_count;
   addrs      = '{32'h0000_0458, 32'h0000_0440, 32'h0000_0450, 32'h0000_0448};
   sent       = 0;
   got        = 0;
   cyc        = 0;
   fetch_req  = 1'b1;
   fetch_addr = addrs[0];
   while (got < 4 && cyc < max_wait) begin
      #2;
      // answer for an earlier accept is checked before this cycle's accept
      if (fetch_data_valid) begin
         if (exp_q.size() == 0) begin
            $display("data valid at %0t ns with no request in flight", $time);
            errors++;
         end else begin
            check_data("fetch_data", fetch_data, exp_q.pop_front());
         end
         resp_cyc.push_back(cyc);
         got++;
      end
      if (fetch_req && fetch_ack) begin
         exp_q.push_back(mem_word(addrs[sent]));
         sent++;
      end
      @(posedge clk);
      #1;
      cyc++;
      if (sent < 4) begin
         fetch_addr = addrs[sent];
      end else begin
         fetch_req = 1'b0;
      end
   end
   fetch_req = 1'b0;
   if (cyc >= max_wait) begin
      $display("timeout at %0t ns, back to back responses missing", $time);
      errors++;
   end
   check_count("responses", got, 4);
   // accepts on cycles 0..3 give answers on 1..4
   for (int i = 0; i < resp_cyc.size(); i++) begin
      check_count("response cycle", resp_cyc[i], i + 1);
   end
   check_count("AR count", ar_count - ar_before, 0);
   report_test("back to back", err_start);
endtask

// a, b and c share set 5
task automatic test_lru();
   int err_start;
   err_start = errors;
   fetch_check(32'h0001_00a0, 1'b0);
   fetch_check(32'h0002_00a8, 1'b0);
   fetch_check(32'h0001_00b0, 1'b1);
   fetch_check(32'h0002_00b8, 1'b1);
   // a touched last so b is lru
   fetch_check(32'h0001_00a0, 1'b1);
   fetch_check(32'h0003_00b0, 1'b0);
   fetch_check(32'h0001_00a8, 1'b1);
   fetch_check(32'h0002_00a0, 1'b0);
   report_test("two ways and lru", err_start);
endtask

// fault on beat 2 flags a beat 0 fetch and leaves the line invalid
task automatic test_fault();
   data_t d;
   logic  f;
   int    lat;
   int    err_start;
   int    ar_before;
   err_start = errors;
   for (int n = 0; n < 2; n++) begin
      ar_before = ar_count;
      fetch(32'h0000_8000, d, f, lat);
      check_bit("fetch_fault", f, 1'b1);
      check_data("fetch_data", d, mem_word(32'h0000_8000));
      check_count("AR count", ar_count - ar_before, 1);
   end
   fetch_check(32'h0000_0440, 1'b1);
   report_test("fault", err_start);
endtask

task automatic test_backpressure();
   int err_start;
   err_start = errors;
   // ar held off for five cycles
   ar_delay  = 5;
   fetch_check(32'h0000_3078, 1'b0);
   ar_delay = 0;
   fetch_check(32'h0000_3060, 1'b1);
   report_test("back-pressure", err_start);
endtask

`endif

//--- tests/icache_tb.sv
`timescale 1ns/1ns

module icache_tb;
   import icache_pkg::*;

   // memory model seed
   localparam logic [31:0] lcg_seed = 32'h05b7eb5b;
   // only beat 2 of line 0x8000 answers SLVERR
   localparam addr_t err_lo = 32'h0000_8010;
   localparam addr_t err_hi = 32'h0000_8018;
   // cycles allowed per wait loop
   localparam int max_wait = 200;

   logic       clk;
   logic       rst;
   logic       fetch_req;
   addr_t      fetch_addr;
   logic       fetch_ack;
   logic       fetch_data_valid;
   data_t      fetch_data;
   logic       fetch_fault;
   addr_t      araddr;
   logic [7:0] arlen;
   logic [2:0] arsize;
   logic [1:0] arburst;
   logic       arvalid;
   logic       arready;
   data_t      rdata;
   logic [1:0] rresp;
   logic       rlast;
   logic       rvalid;
   logic       rready;

   // run bookkeeping
   int errors = 0;
   int tests_run = 0;
   int tests_failed = 0;

   // captured by the slave for the tests
   int         ar_count = 0;
   int         ar_delay = 0;
   addr_t      last_araddr;
   logic [7:0] last_arlen;
   logic [2:0] last_arsize;
   logic [1:0] last_arburst;

   icache_top icache_top_inst (
      .clk              (clk             ),
      .rst              (rst             ),
      .fetch_req        (fetch_req       ),
      .fetch_addr       (fetch_addr      ),
      .fetch_ack        (fetch_ack       ),
      .fetch_data_valid (fetch_data_valid),
      .fetch_data       (fetch_data      ),
      .fetch_fault      (fetch_fault     ),
      .araddr           (araddr          ),
      .arlen            (arlen           ),
      .arsize           (arsize          ),
      .arburst          (arburst         ),
      .arvalid          (arvalid         ),
      .arready          (arready         ),
      .rdata            (rdata           ),
      .rresp            (rresp           ),
      .rlast            (rlast           ),
      .rvalid           (rvalid          ),
      .rready           (rready          )
   );

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // numerical recipes constants
   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // two steps give the two halves of a doubleword
   function automatic data_t mem_word(input addr_t a);
      logic [31:0] lo;
      logic [31:0] hi;
      lo = lcg(lcg_seed ^ a);
      hi = lcg(lo);
      return {hi, lo};
   endfunction

   function automatic addr_t dword_base(input addr_t a);
      return {a[addr_w-1:3], 3'b000};
   endfunction

   // 32 byte lines
   function automatic addr_t line_base(input addr_t a);
      return a & 32'hffff_ffe0;
   endfunction

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("FAIL %0t ns %s: got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp) begin
         $display("FAIL %0t ns %s: got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %0t ns %s: got %b expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   // ar fields with the narrower ones zero extended
   task automatic check_field(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("FAIL %0t ns %s: got %0d expected %0d", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("FAIL %0t ns %s: got %0d expected %0d", $time, name, got, exp);
         errors++;
      end
   endtask

   // axi read slave driving 1 ns after the edge
   initial begin : axi_slave
      addr_t base;
      addr_t beat_addr;
      int    dly;
      arready = 1'b0;
      rvalid  = 1'b0;
      rlast   = 1'b0;
      rresp   = 2'b00;
      rdata   = '0;
      forever begin
         dly = 0;
         @(posedge clk);
         #1;
         // address must not move while arready is held back
         while (!(arvalid && dly >= ar_delay)) begin
            if (arvalid) begin
               if (dly == 0) begin
                  base = araddr;
               end else begin
                  check_addr("araddr while stalled", araddr, base);
               end
               dly++;
            end else if (dly > 0) begin
               $display("arvalid went low at %0t ns before arready", $time);
               errors++;
               dly = 0;
            end
            @(posedge clk);
            #1;
         end
         if (dly > 0) begin
            check_addr("araddr while stalled", araddr, base);
         end
         base         = araddr;
         arready      = 1'b1;
         last_araddr  = araddr;
         last_arlen   = arlen;
         last_arsize  = arsize;
         last_arburst = arburst;
         ar_count++;
         @(posedge clk);
         #1;
         arready = 1'b0;
         // incr burst with one beat per cycle
         for (int k = 0; k < line_beats; k++) begin
            check_bit("rready", rready, 1'b1);
            beat_addr = base + addr_t'(8 * k);
            rvalid    = 1'b1;
            rdata     = mem_word(beat_addr);
            rresp     = (beat_addr >= err_lo && beat_addr < err_hi) ? 2'b10 : 2'b00;
            rlast     = (k == line_beats - 1);
            @(posedge clk);
            #1;
         end
         rvalid = 1'b0;
         rlast  = 1'b0;
         rresp  = 2'b00;
      end
   end

   `include "icache_tests.svh"

   initial begin
      rst        = 1'b1;
      fetch_req  = 1'b0;
      fetch_addr = '0;
      repeat (4) begin
         @(posedge clk);
      end
      #1;
      rst = 1'b0;
      test_reset();
      test_cold_miss();
      test_hits();
      test_back_to_back();
      test_lru();
      test_fault();
      test_backpressure();
      $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule
